//--- Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/decode_pkg.sv
      - logic/decode_control.sv
      - logic/register_file.sv
      - logic/imm_gen.sv
      - logic/instr_decode.sv
      - logic/decode_stage.sv
  - target: test
    files:
      - verif/decode_stage_assert.sv
      - verif/decode_stage_tb.sv

//--- compile.f
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/decode_control.sv
logic/register_file.sv
logic/imm_gen.sv
logic/instr_decode.sv
logic/decode_stage.sv
verif/decode_stage_assert.sv
verif/decode_stage_tb.sv

//--- logic/decode_control.sv
`timescale 1ns/10ps

module decode_control (
  input  isa_pkg::instr_u    instr,
  output decode_pkg::ctrl_t ctrl,
  output logic              err
);

  always_comb begin
    ctrl = '0; // Everything low unless an opcode sets it
    err  = 1'b0;
    case (instr.r.opcode)
      isa_pkg::ADDI: begin
        ctrl.reg_write    = 1'b1;
        ctrl.five_bit_imm = 1'b1;
      end
      isa_pkg::ANDNI: begin
        ctrl.reg_write    = 1'b1;
        ctrl.five_bit_imm = 1'b1;
        ctrl.zero_extend  = 1'b1;
      end
      isa_pkg::LD: begin
        ctrl.reg_write    = 1'b1;
        ctrl.five_bit_imm = 1'b1;
      end
      isa_pkg::LBI: begin
        ctrl.reg_write = 1'b1; // Signed 8-bit immediate into rs
      end
      isa_pkg::SLBI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.zero_extend = 1'b1;
      end
      isa_pkg::ST: begin
        // Offset from imm5, no register write
        ctrl.mem_write    = 1'b1;
        ctrl.five_bit_imm = 1'b1;
      end
      isa_pkg::ADD: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
      end
      isa_pkg::J: begin
        ctrl.jump = 1'b1;
      end
      isa_pkg::HALT: begin
        ctrl.halt = 1'b1;
      end
      isa_pkg::NOP: begin
        ctrl = '0;
      end
      default: begin
        // Illegal opcode, keep the bundle low so nothing is written
        ctrl = '0;
        err  = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/decode_pkg.sv
package decode_pkg;

  localparam int data_w = 16;

  // Control levels for the rest of the datapath
  typedef struct packed {
    logic reg_write;    // Register file write strobe
    logic reg_dst;      // Write to rd instead of rs
    logic five_bit_imm; // Use imm5, also selects rt as write register
    logic zero_extend;
    logic mem_write;    // Store, swaps operand order
    logic jump;
    logic halt;
  } ctrl_t;

  // Everything the decode stage hands to execute
  typedef struct packed {
    logic [data_w-1:0] read1_data;
    logic [data_w-1:0] read2_data;
    logic [data_w-1:0] immediate;
    logic [data_w-1:0] jump_addr;
  } operands_t;

endpackage

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic                          clk,
  input  logic                          reset,
  input  isa_pkg::instr_u               instr,
  input  logic [isa_pkg::pc_hi_w-1:0]   pc_hi,
  input  logic [decode_pkg::data_w-1:0] write_data,
  output decode_pkg::ctrl_t             ctrl,
  output decode_pkg::operands_t         ops,
  output logic                          err
);

  decode_control u_ctrl (
    .instr (instr),
    .ctrl  (ctrl),
    .err   (err)
  );

  // Control bundle also steers the register write and operand order
  instr_decode u_decode (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .pc_hi      (pc_hi),
    .write_data (write_data),
    .ctrl       (ctrl),
    .ops        (ops)
  );

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/10ps

module imm_gen (
  input  isa_pkg::instr_u                instr,
  input  logic [isa_pkg::pc_hi_w-1:0]    pc_hi,
  input  logic                           five_bit_imm,
  input  logic                           zero_extend,
  output logic [decode_pkg::data_w-1:0]  immediate,
  output logic [decode_pkg::data_w-1:0]  jump_addr
);

  logic [4:0]                    imm5;
  logic [7:0]                    imm8;
  logic [decode_pkg::data_w-1:0] sext5, zext5, sext8, zext8;
  logic [decode_pkg::data_w-1:0] sext_sel, zext_sel;

  assign imm5 = instr.i.imm5;
  assign imm8 = {instr.i.rt, instr.i.imm5}; // Low byte of the word

  assign sext5 = {{(decode_pkg::data_w-5){imm5[4]}}, imm5};
  assign zext5 = {{(decode_pkg::data_w-5){1'b0}}, imm5};
  assign sext8 = {{(decode_pkg::data_w-8){imm8[7]}}, imm8};
  assign zext8 = {{(decode_pkg::data_w-8){1'b0}}, imm8};

  // Field width first, then extension kind
  assign sext_sel  = five_bit_imm ? sext5 : sext8;
  assign zext_sel  = five_bit_imm ? zext5 : zext8;
  assign immediate = zero_extend ? zext_sel : sext_sel;

  // Upper PC bits joined above the displacement
  assign jump_addr = {pc_hi, instr.j.disp11};

endmodule

//--- logic/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
  input  logic                          clk,
  input  logic                          reset,
  input  isa_pkg::instr_u               instr,
  input  logic [isa_pkg::pc_hi_w-1:0]   pc_hi,
  input  logic [decode_pkg::data_w-1:0] write_data,
  input  decode_pkg::ctrl_t             ctrl,
  output decode_pkg::operands_t         ops
);

  isa_pkg::reg_idx_t rs, rt, rd;
  isa_pkg::reg_idx_t write_sel;

  logic [decode_pkg::data_w-1:0] rt_data; // Port 1
  logic [decode_pkg::data_w-1:0] rs_data; // Port 2
  logic [decode_pkg::data_w-1:0] immediate, jump_addr;

  assign rs = instr.r.rs;
  assign rt = instr.r.rt;
  assign rd = instr.r.rd;

  // Immediate forms write rt, R format writes rd, LBI and SLBI write rs
  always_comb begin
    if (ctrl.five_bit_imm) begin
      write_sel = rt;
    end else if (ctrl.reg_dst) begin
      write_sel = rd;
    end else begin
      write_sel = rs;
    end
  end

  register_file u_regs (
    .clk        (clk),
    .reset      (reset),
    .read1_sel  (rt),
    .read2_sel  (rs),
    .write_sel  (write_sel),
    .write_data (write_data),
    .write      (ctrl.reg_write),
    .read1_data (rt_data),
    .read2_data (rs_data)
  );

  imm_gen u_imm (
    .instr        (instr),
    .pc_hi        (pc_hi),
    .five_bit_imm (ctrl.five_bit_imm),
    .zero_extend  (ctrl.zero_extend),
    .immediate    (immediate),
    .jump_addr    (jump_addr)
  );

  // Stores put the base register first
  assign ops.read1_data = ctrl.mem_write ? rs_data : rt_data;
  assign ops.read2_data = ctrl.mem_write ? rt_data : rs_data;
  assign ops.immediate  = immediate;
  assign ops.jump_addr  = jump_addr;

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int num_regs = 8;
  localparam int pc_hi_w  = 5; // Upper PC bits placed above disp11

  typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

  // Major opcode in bits 15:11, codes not listed are illegal
  typedef enum logic [4:0] {
    HALT  = 5'b00000,
    NOP   = 5'b00001,
    J     = 5'b00100,
    ADDI  = 5'b01000,
    ANDNI = 5'b01011,
    ST    = 5'b10000,
    LD    = 5'b10001,
    SLBI  = 5'b10010,
    LBI   = 5'b11000,
    ADD   = 5'b11011
  } opcode_t;

  // Register-register format
  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rs;     // Bits 10:8
    reg_idx_t   rt;     // Bits 7:5
    reg_idx_t   rd;     // Bits 4:2
    logic [1:0] func;
  } instr_r_t;

  // Immediate format, the 8-bit immediate spans rt and imm5
  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    logic [4:0] imm5;
  } instr_i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [10:0] disp11; // Jump displacement
  } instr_j_t;

  // One instruction word seen in all three formats
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_j_t j;
  } instr_u;

endpackage

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                         clk,
  input  logic                         reset,
  input  isa_pkg::reg_idx_t            read1_sel,
  input  isa_pkg::reg_idx_t            read2_sel,
  input  isa_pkg::reg_idx_t            write_sel,
  input  logic [decode_pkg::data_w-1:0] write_data,
  input  logic                         write,
  output logic [decode_pkg::data_w-1:0] read1_data,
  output logic [decode_pkg::data_w-1:0] read2_data
);

  logic [decode_pkg::data_w-1:0] regs [isa_pkg::num_regs];

  // Reset wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[write_sel] <= write_data;
    end
  end

  // Reads are combinational, no bypass of the value being written
  assign read1_data = regs[read1_sel];
  assign read2_data = regs[read2_sel];

endmodule

//--- verif/decode_stage_assert.sv
`timescale 1ns/10ps

module decode_stage_assert (
  input logic                  clk,
  input logic                  reset,
  input decode_pkg::ctrl_t     ctrl,
  input decode_pkg::operands_t ops,
  input logic                  err
);

  // Illegal opcode keeps every control level low
  property err_clears_ctrl;
    @(posedge clk) disable iff (reset) err |-> (ctrl == '0);
  endproperty

  property no_store_with_write;
    @(posedge clk) disable iff (reset) !(ctrl.mem_write && ctrl.reg_write);
  endproperty

  property outputs_known;
    @(posedge clk) disable iff (reset) !$isunknown({ctrl, ops, err});
  endproperty

  a_err_clears_ctrl: assert property (err_clears_ctrl)
    else $error("err is high while a control bit is set");
  a_no_store_with_write: assert property (no_store_with_write)
    else $error("mem_write and reg_write are high together");
  a_outputs_known: assert property (outputs_known)
    else $error("decode output is unknown out of reset");

endmodule

//--- verif/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

  localparam int reset_cycles = 4;

  typedef struct packed {
    logic [15:0]                   word;
    logic [isa_pkg::pc_hi_w-1:0]   pc_hi;
    logic [decode_pkg::data_w-1:0] write_data;
    logic                          exp_err;
  } entry_t;

  logic                          clk;
  logic                          reset;
  isa_pkg::instr_u               instr;
  logic [isa_pkg::pc_hi_w-1:0]   pc_hi;
  logic [decode_pkg::data_w-1:0] write_data;
  decode_pkg::ctrl_t             ctrl;
  decode_pkg::operands_t         ops;
  logic                          err;

  entry_t      stim [$];
  logic [15:0] model_regs [isa_pkg::num_regs]; // Expected register contents
  logic [31:0] rng_state = 32'd29211;
  int          ctrl_errors = 0;
  int          ops_errors = 0;
  int          err_errors = 0;
  int          cycles = 0;
  int          cycle_limit = 1000; // Replaced once the table is built

  decode_stage dut (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .pc_hi      (pc_hi),
    .write_data (write_data),
    .ctrl       (ctrl),
    .ops        (ops),
    .err        (err)
  );

  bind decode_stage decode_stage_assert u_assert (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .ops   (ops),
    .err   (err)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, table did not finish", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit opcode_legal(logic [4:0] code);
    case (code)
      isa_pkg::ADDI, isa_pkg::ANDNI, isa_pkg::LBI, isa_pkg::SLBI, isa_pkg::LD,
      isa_pkg::ST, isa_pkg::ADD, isa_pkg::J, isa_pkg::NOP, isa_pkg::HALT: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic decode_pkg::ctrl_t expected_ctrl(logic [4:0] code);
    decode_pkg::ctrl_t c;
    c = '0;
    case (code)
      isa_pkg::ADDI, isa_pkg::LD: begin
        c.reg_write    = 1'b1;
        c.five_bit_imm = 1'b1;
      end
      isa_pkg::ANDNI: begin
        c.reg_write    = 1'b1;
        c.five_bit_imm = 1'b1;
        c.zero_extend  = 1'b1;
      end
      isa_pkg::LBI: c.reg_write = 1'b1;
      isa_pkg::SLBI: begin
        c.reg_write   = 1'b1;
        c.zero_extend = 1'b1;
      end
      isa_pkg::ST: begin
        c.mem_write    = 1'b1;
        c.five_bit_imm = 1'b1;
      end
      isa_pkg::ADD: begin
        c.reg_write = 1'b1;
        c.reg_dst   = 1'b1;
      end
      isa_pkg::J: c.jump = 1'b1;
      isa_pkg::HALT: c.halt = 1'b1;
      default: c = '0;
    endcase
    return c;
  endfunction

  // rs in bits 10:8, rt in 7:5, rd in 4:2
  function automatic logic [2:0] write_target(logic [15:0] w, decode_pkg::ctrl_t c);
    if (c.five_bit_imm) return w[7:5];
    if (c.reg_dst) return w[4:2];
    return w[10:8];
  endfunction

  function automatic decode_pkg::operands_t expected_ops(entry_t e, decode_pkg::ctrl_t c);
    decode_pkg::operands_t o;
    logic [15:0] rs_val;
    logic [15:0] rt_val;
    rs_val = model_regs[e.word[10:8]];
    rt_val = model_regs[e.word[7:5]];
    o.read1_data = c.mem_write ? rs_val : rt_val;
    o.read2_data = c.mem_write ? rt_val : rs_val;
    if (c.five_bit_imm)
      o.immediate = c.zero_extend ? {11'h000, e.word[4:0]} : {{11{e.word[4]}}, e.word[4:0]};
    else
      o.immediate = c.zero_extend ? {8'h00, e.word[7:0]} : {{8{e.word[7]}}, e.word[7:0]};
    o.jump_addr = {e.pc_hi, e.word[10:0]};
    return o;
  endfunction

  function automatic logic [15:0] r_word(logic [4:0] op, logic [2:0] rs, rt, rd);
    return {op, rs, rt, rd, 2'b00};
  endfunction

  function automatic logic [15:0] i_word(logic [4:0] op, logic [2:0] rs, rt, logic [4:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic add_entry(logic [15:0] word, logic [4:0] pc_val);
    entry_t e;
    rng_state    = xorshift(rng_state);
    e.word       = word;
    e.pc_hi      = pc_val;
    e.write_data = rng_state[15:0];
    e.exp_err    = !opcode_legal(word[15:11]);
    stim.push_back(e);
  endtask

  task automatic build_table();
    for (int k = 0; k < 4; k++) begin
      // Reads every register once, writes only ones already read
      add_entry(r_word(isa_pkg::ADD, 3'(2 * k), 3'(2 * k + 1), 3'(2 * k)), 5'h03);
    end
    add_entry(i_word(isa_pkg::LBI, 3'd3, 3'd4, 5'h05), 5'h0c);  // rs written, imm8 0x85
    add_entry(r_word(isa_pkg::ADD, 3'd1, 3'd2, 3'd5), 5'h11);   // rd written
    add_entry(i_word(isa_pkg::ADDI, 3'd0, 3'd6, 5'h13), 5'h07); // rt written
    add_entry(r_word(isa_pkg::ADD, 3'd3, 3'd6, 3'd7), 5'h1e);
    add_entry(i_word(isa_pkg::ST, 3'd5, 3'd3, 5'h02), 5'h09);
    add_entry(i_word(isa_pkg::ADDI, 3'd1, 3'd2, 5'h16), 5'h00); // Negative fields
    add_entry(i_word(isa_pkg::ANDNI, 3'd4, 3'd0, 5'h19), 5'h0f);
    add_entry(i_word(isa_pkg::LBI, 3'd2, 3'd7, 5'h10), 5'h14);  // imm8 0xf0
    add_entry(i_word(isa_pkg::SLBI, 3'd6, 3'd4, 5'h1c), 5'h1b); // imm8 0x9c
    add_entry(i_word(isa_pkg::LD, 3'd4, 3'd6, 5'h1d), 5'h02);
    add_entry(i_word(isa_pkg::ST, 3'd4, 3'd6, 5'h1d), 5'h02);
    add_entry({isa_pkg::J, 11'h5a3}, 5'h15);
    add_entry({isa_pkg::J, 11'h07f}, 5'h0a);
    add_entry(r_word(isa_pkg::HALT, 3'd1, 3'd3, 3'd5), 5'h01);
    add_entry(r_word(isa_pkg::NOP, 3'd2, 3'd4, 3'd6), 5'h1f);
    for (int c = 0; c < 32; c++) begin
      if (!opcode_legal(c[4:0])) add_entry(i_word(c[4:0], 3'd2, 3'd5, 5'h1f), 5'h1f);
    end
    for (int k = 0; k < 4; k++) begin
      add_entry(i_word(isa_pkg::ST, 3'(2 * k), 3'(2 * k + 1), 5'h00), 5'h06); // Reads, no write
    end
  endtask

  task automatic check_ctrl(decode_pkg::ctrl_t got, decode_pkg::ctrl_t exp, int idx);
    if (got !== exp) begin
      $display("Mismatch entry %0d ctrl: got %h expected %h", idx, got, exp);
      ctrl_errors++;
    end
  endtask

  task automatic check_ops(decode_pkg::operands_t got, decode_pkg::operands_t exp, int idx);
    if (got.read1_data !== exp.read1_data)
      $display("Mismatch entry %0d ops.read1_data: got %h expected %h", idx,
               got.read1_data, exp.read1_data);
    if (got.read2_data !== exp.read2_data)
      $display("Mismatch entry %0d ops.read2_data: got %h expected %h", idx,
               got.read2_data, exp.read2_data);
    if (got.immediate !== exp.immediate)
      $display("Mismatch entry %0d ops.immediate: got %h expected %h", idx,
               got.immediate, exp.immediate);
    if (got.jump_addr !== exp.jump_addr)
      $display("Mismatch entry %0d ops.jump_addr: got %h expected %h", idx,
               got.jump_addr, exp.jump_addr);
    if (got !== exp) ops_errors++;
  endtask

  task automatic check_err(bit got, bit exp, int idx);
    if (got != exp) begin
      $display("Mismatch entry %0d err: got %h expected %h", idx, got, exp);
      err_errors++;
    end
  endtask

  initial begin
    decode_pkg::ctrl_t     exp_c;
    decode_pkg::operands_t exp_o;
    reset      = 1'b1;
    instr      = {isa_pkg::NOP, 11'h000};
    pc_hi      = '0;
    write_data = '0;
    build_table();
    cycle_limit = reset_cycles + stim.size() + 20;
    for (int r = 0; r < isa_pkg::num_regs; r++) begin
      model_regs[r] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int n = 0; n < stim.size(); n++) begin
      @(negedge clk);
      instr      = stim[n].word;
      pc_hi      = stim[n].pc_hi;
      write_data = stim[n].write_data;
      #2;
      exp_c = expected_ctrl(stim[n].word[15:11]);
      exp_o = expected_ops(stim[n], exp_c);
      check_ctrl(ctrl, exp_c, n);
      check_ops(ops, exp_o, n);
      check_err(err, stim[n].exp_err, n);
      @(posedge clk);
      if (exp_c.reg_write) model_regs[write_target(stim[n].word, exp_c)] = stim[n].write_data;
    end
    $display("Errors: %0d total, %0d ctrl, %0d ops, %0d err",
             ctrl_errors + ops_errors + err_errors, ctrl_errors, ops_errors, err_errors);
    if (ctrl_errors + ops_errors + err_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
